// ==== branch_path.f ====
+incdir+source
source/branch_pkg.sv
source/btb_if.sv
source/branch_lut.sv
source/branch_unit.sv
source/fetch_pc.sv
source/branch_path.sv
sim/branch_path_checker.sv
sim/tb_branch_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the branch path testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f branch_path.f \
  --top-module tb_branch_path -o sim_branch_path > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_branch_path > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== sim/branch_path_checker.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module branch_path_checker (
  input logic                       clk,
  input logic                       rst,
  input logic                       stall,
  input logic [`NUM_PIPE_MASKS-1:0] flush,
  input logic [`ADDR_WIDTH-1:0]     jump_address,
  input logic [`ADDR_WIDTH-1:0]     pc,
  input logic                       take_branch
);

  int failures = 0;  // failed assertions so far.

  flush_all_or_none: assert property (@(posedge clk) disable iff (rst)
      (flush == '0) || (flush == `PIPE_FLUSH_ALL))
    else begin
      failures++;
      $error("flush mask %b is neither empty nor full", flush);
    end

  // redirect must win even while fetch is held.
  redirect_beats_stall: assert property (@(posedge clk) disable iff (rst)
      ((flush != '0) && stall) |=> (pc == $past(jump_address)))
    else begin
      failures++;
      $error("pc did not follow the redirect during a stall");
    end

  no_prediction_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !take_branch)
    else begin
      failures++;
      $error("take_branch high in the first cycle after reset");
    end

endmodule

bind branch_path branch_path_checker u_checker (
  .clk          (clk),
  .rst          (rst),
  .stall        (stall),
  .flush        (flush),
  .jump_address (jump_address),
  .pc           (pc),
  .take_branch  (take_branch)
);

`default_nettype wire

// ==== sim/tb_branch_path.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module tb_branch_path;

  localparam int RESET_TIMEOUT = 20;
  localparam int DEPTH = `BTB_DEPTH;

  typedef struct packed {
    branch_pkg::jump_op_t    op;
    logic [2:0]              flags;  // zero, less, greater.
    logic                    pred;
    logic [`ADDR_WIDTH-1:0]  at;
    logic [`ADDR_WIDTH-1:0]  reg_addr;
    logic [`ADDR_WIDTH-1:0]  imm_addr;
    logic                    hold;
    branch_pkg::flush_mask_t exp_flush;
    logic [`ADDR_WIDTH-1:0]  exp_jump;
  } row_t;

  logic clk;
  logic rst;
  logic zero;
  logic less;
  logic greater;
  logic branch_taken;
  logic stall;
  branch_pkg::jump_op_t jop;
  logic [`ADDR_WIDTH-1:0] id_ex_pc;
  logic [`ADDR_WIDTH-1:0] id_ex_reg_address;
  logic [`ADDR_WIDTH-1:0] id_ex_imm_address;
  logic [`ADDR_WIDTH-1:0] pc;
  logic take_branch;
  logic [`ADDR_WIDTH-1:0] branch_predict;
  branch_pkg::flush_mask_t flush;
  logic [`ADDR_WIDTH-1:0] jump_address;

  row_t rows[$];
  logic [31:0] rng = 32'he8b6dee3;
  int errors = 0;
  int checks = 0;

  // reference state of fetch and the target buffer.
  logic [`ADDR_WIDTH-1:0] m_pc;
  logic [`ADDR_WIDTH-1:0] m_key [DEPTH];
  logic [`ADDR_WIDTH-1:0] m_tgt [DEPTH];
  logic                   m_valid [DEPTH];

  branch_path uut (
    .clk (clk), .rst (rst), .zero (zero), .less (less), .greater (greater),
    .jop (jop), .branch_taken (branch_taken), .id_ex_pc (id_ex_pc),
    .id_ex_reg_address (id_ex_reg_address), .id_ex_imm_address (id_ex_imm_address),
    .stall (stall), .pc (pc), .take_branch (take_branch),
    .branch_predict (branch_predict), .flush (flush), .jump_address (jump_address)
  );

  always #10 clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_taken(input branch_pkg::jump_op_t op, input logic [2:0] f);
    logic z;
    logic l;
    logic g;
    z = f[2];
    l = f[1];
    g = f[0];
    if (op == branch_pkg::J || op == branch_pkg::JR) return 1'b1;
    if (op == branch_pkg::JEQ || op == branch_pkg::JZ) return z;
    if (op == branch_pkg::JNE || op == branch_pkg::JNZ) return !z;
    if (op == branch_pkg::JL) return l;
    if (op == branch_pkg::JLE) return l || z;
    if (op == branch_pkg::JG) return g;
    if (op == branch_pkg::JGE) return g || z;
    return 1'b0;
  endfunction

  function automatic logic is_redirect(input branch_pkg::jump_op_t op, input logic [2:0] f,
                                       input logic pred);
    return (is_taken(op, f) != pred) || (op == branch_pkg::JR);
  endfunction

  function automatic logic [`ADDR_WIDTH-1:0] target_of(input row_t r);
    if (r.op == branch_pkg::JR) return r.reg_addr;
    if (!is_taken(r.op, r.flags)) return r.at + 16'd1;
    return r.imm_addr;
  endfunction

  task automatic add_row(input branch_pkg::jump_op_t op, input logic [2:0] f, input logic pred,
                         input logic [15:0] at, input logic [15:0] ra, input logic [15:0] ia,
                         input logic hold, input logic [3:0] ef, input logic [15:0] ej);
    row_t r;
    r = '{op, f, pred, at, ra, ia, hold, ef, ej};
    rows.push_back(r);
  endtask

  // expectations for generated rows come from the resolution rules.
  task automatic add_model_row(input branch_pkg::jump_op_t op, input logic [2:0] f,
                               input logic pred, input logic hold);
    row_t r;
    rng = xorshift(rng);
    r = '{op, f, pred, rng[15:0], rng[31:16], rng[23:8], hold, 4'h0, 16'h0};
    r.exp_flush = is_redirect(op, f, pred) ? 4'hf : 4'h0;
    r.exp_jump = target_of(r);
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::JEQ, 3'b100, 0, 16'h0005, 16'h0000, 16'h0040, 1, 4'hf, 16'h0040);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 1, 4'h0, 16'h0001);
    add_row(branch_pkg::J,   3'b000, 0, 16'h0041, 16'h0000, 16'h0004, 0, 4'hf, 16'h0004);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::JR,  3'b000, 1, 16'h0030, 16'h0030, 16'h0099, 0, 4'hf, 16'h0030);
    add_row(branch_pkg::NOP, 3'b000, 0, 16'h0000, 16'h0000, 16'h0000, 0, 4'h0, 16'h0001);
    add_row(branch_pkg::JLE, 3'b100, 0, 16'h0100, 16'h0000, 16'h0200, 0, 4'hf, 16'h0200);
    add_row(branch_pkg::JGE, 3'b000, 1, 16'h0200, 16'h0000, 16'h0300, 0, 4'hf, 16'h0201);
    add_row(branch_pkg::JNE, 3'b000, 1, 16'h0201, 16'h0000, 16'h0010, 0, 4'h0, 16'h0010);
    add_row(branch_pkg::JR,  3'b000, 0, 16'h0202, 16'h0abc, 16'h0010, 0, 4'hf, 16'h0abc);
    for (int op = 3; op <= 10; op++) begin
      for (int f = 0; f < 8; f++) begin
        for (int p = 0; p < 2; p++) begin
          add_model_row(branch_pkg::jump_op_t'(op[3:0]), f[2:0], p[0], rng[5]);
        end
      end
    end
    for (int i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      add_model_row(branch_pkg::jump_op_t'(rng[3:0]), rng[6:4], rng[7], rng[9] & rng[8]);
    end
  endtask

  task automatic apply_row(input row_t r);
    jop = r.op;
    {zero, less, greater} = r.flags;
    branch_taken = r.pred;
    id_ex_pc = r.at;
    id_ex_reg_address = r.reg_addr;
    id_ex_imm_address = r.imm_addr;
    stall = r.hold;
  endtask

  task automatic check_outputs(input row_t r);
    logic [`BTB_INDEX_BITS-1:0] idx;
    logic exp_take;
    idx = m_pc[`BTB_INDEX_BITS-1:0];
    exp_take = m_valid[idx] && (m_key[idx] == m_pc);
    checks += 5;
    assert (pc === m_pc) else begin
      errors++;
      $display("MISMATCH %0t: pc got %h expected %h", $time, pc, m_pc);
    end
    assert (take_branch === exp_take) else begin
      errors++;
      $display("MISMATCH %0t: take_branch got %b expected %b", $time, take_branch, exp_take);
    end
    assert (!exp_take || branch_predict === m_tgt[idx]) else begin
      errors++;
      $display("MISMATCH %0t: branch_predict got %h expected %h", $time, branch_predict,
               m_tgt[idx]);
    end
    assert (flush === r.exp_flush) else begin
      errors++;
      $display("MISMATCH %0t: flush got %b expected %b", $time, flush, r.exp_flush);
    end
    assert (jump_address === r.exp_jump) else begin
      errors++;
      $display("MISMATCH %0t: jump_address got %h expected %h", $time, jump_address,
               r.exp_jump);
    end
  endtask

  // advance the model over the coming clock edge.
  task automatic model_step();
    row_t cur;
    logic [`BTB_INDEX_BITS-1:0] idx;
    logic [`ADDR_WIDTH-1:0] tgt;
    cur = '{jop, {zero, less, greater}, branch_taken, id_ex_pc, id_ex_reg_address,
            id_ex_imm_address, stall, 4'h0, 16'h0};
    idx = m_pc[`BTB_INDEX_BITS-1:0];
    tgt = target_of(cur);
    if (is_redirect(cur.op, cur.flags, cur.pred)) m_pc = tgt;
    else if (!stall && m_valid[idx] && m_key[idx] == m_pc) m_pc = m_tgt[idx];
    else if (!stall) m_pc = m_pc + 16'd1;
    if (is_redirect(cur.op, cur.flags, cur.pred) && is_taken(cur.op, cur.flags)
        && cur.op != branch_pkg::JR) begin
      idx = cur.at[`BTB_INDEX_BITS-1:0];
      m_key[idx] = cur.at;
      m_tgt[idx] = tgt;
      m_valid[idx] = 1'b1;
    end
  endtask

  task automatic wait_reset(output logic released);
    int n;
    n = 0;
    while ((rst !== 1'b0) && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    released = (rst === 1'b0);
  endtask

  initial begin
    logic released;
    clk = 1'b0;
    apply_row('{branch_pkg::NOP, 3'b000, 1'b0, 16'h0, 16'h0, 16'h0, 1'b0, 4'h0, 16'h1});
    m_pc = '0;
    for (int i = 0; i < DEPTH; i++) m_valid[i] = 1'b0;
    build_table();
    wait_reset(released);
    if (!released) begin
      errors++;
      $display("reset was still active after %0d cycles", RESET_TIMEOUT);
    end else begin
      check_outputs(rows[0]);  // idle state right after reset.
      model_step();
      foreach (rows[i]) begin
        @(posedge clk);
        #1 apply_row(rows[i]);
        #5 check_outputs(rows[i]);
        model_step();
      end
    end
    errors += uut.u_checker.failures;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/branch_consts.svh ====
`default_nettype none

`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

// instruction address width.
`define ADDR_WIDTH 16

// jump opcode width.
`define JUMP_BITS 4

// one flush bit per pipeline register.
`define NUM_PIPE_MASKS 4

`define PIPE_REG_PC     4'b0001
`define PIPE_REG_IF_ID  4'b0010
`define PIPE_REG_ID_EX  4'b0100
`define PIPE_REG_EX_MEM 4'b1000

`define PIPE_FLUSH_ALL (`PIPE_REG_PC | `PIPE_REG_IF_ID | `PIPE_REG_ID_EX | `PIPE_REG_EX_MEM)

// direct mapped, indexed by low pc bits.
`define BTB_INDEX_BITS 4
`define BTB_DEPTH      (1 << `BTB_INDEX_BITS)

`endif

`default_nettype wire

// ==== source/branch_lut.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module branch_lut (
  input logic clk,
  input logic rst,
  btb_if.lut  btb
);

  localparam int TAG_BITS = `ADDR_WIDTH - `BTB_INDEX_BITS;

  logic [TAG_BITS-1:0]    tag_mem    [`BTB_DEPTH];
  logic [`ADDR_WIDTH-1:0] target_mem [`BTB_DEPTH];
  logic [`BTB_DEPTH-1:0]  valid;

  logic [`BTB_INDEX_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0]        wr_tag;
  logic [`BTB_INDEX_BITS-1:0] rd_index;
  logic [TAG_BITS-1:0]        rd_tag;

  // low bits pick the entry, the rest is the tag.
  assign wr_index = btb.write_key[`BTB_INDEX_BITS-1:0];
  assign wr_tag   = btb.write_key[`ADDR_WIDTH-1:`BTB_INDEX_BITS];
  assign rd_index = btb.read_key[`BTB_INDEX_BITS-1:0];
  assign rd_tag   = btb.read_key[`ADDR_WIDTH-1:`BTB_INDEX_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;  // all entries empty.
    end else if (btb.write) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (btb.write) begin
      tag_mem[wr_index]    <= wr_tag;
      target_mem[wr_index] <= btb.write_val;  // replaces any older entry.
    end
  end

  // lookup is combinational on the fetch pc.
  always_comb begin
    btb.read_val   = target_mem[rd_index];
    btb.read_valid = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
  end

endmodule

`default_nettype wire

// ==== source/branch_path.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module branch_path (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    zero,
  input  logic                    less,
  input  logic                    greater,
  input  branch_pkg::jump_op_t    jop,
  input  logic                    branch_taken,
  input  logic [`ADDR_WIDTH-1:0]  id_ex_pc,
  input  logic [`ADDR_WIDTH-1:0]  id_ex_reg_address,
  input  logic [`ADDR_WIDTH-1:0]  id_ex_imm_address,
  input  logic                    stall,
  output logic [`ADDR_WIDTH-1:0]  pc,
  output logic                    take_branch,
  output logic [`ADDR_WIDTH-1:0]  branch_predict,
  output branch_pkg::flush_mask_t flush,
  output logic [`ADDR_WIDTH-1:0]  jump_address
);

  btb_if btb ();

  branch_lut u_lut (
    .clk (clk),
    .rst (rst),
    .btb (btb)
  );

  branch_unit u_branch_unit (
    .zero              (zero),
    .less              (less),
    .greater           (greater),
    .branch_taken      (branch_taken),
    .jop               (jop),
    .id_ex_pc          (id_ex_pc),
    .id_ex_reg_address (id_ex_reg_address),
    .id_ex_imm_address (id_ex_imm_address),
    .flush             (flush),
    .jump_address      (jump_address),
    .btb               (btb)
  );

  fetch_pc u_fetch_pc (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .flush        (flush),
    .jump_address (jump_address),
    .pc           (pc),
    .btb          (btb)
  );

  // prediction for the instruction now at pc.
  assign take_branch    = btb.read_valid;
  assign branch_predict = btb.read_val;

endmodule

`default_nettype wire

// ==== source/branch_pkg.sv ====
`include "branch_consts.svh"
`default_nettype none

package branch_pkg;

  // jump opcodes as decoded in execute.
  typedef enum logic [`JUMP_BITS-1:0] {
    NOP = 4'd0,
    J   = 4'd1,  // unconditional.
    JR  = 4'd2,  // target from register.
    JEQ = 4'd3,
    JNE = 4'd4,
    JL  = 4'd5,
    JLE = 4'd6,
    JG  = 4'd7,
    JGE = 4'd8,
    JZ  = 4'd9,
    JNZ = 4'd10
  } jump_op_t;

  // one bit per pipeline register to clear.
  typedef logic [`NUM_PIPE_MASKS-1:0] flush_mask_t;

endpackage

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module branch_unit (
  input  logic                      zero,
  input  logic                      less,
  input  logic                      greater,
  input  logic                      branch_taken,
  input  branch_pkg::jump_op_t      jop,
  input  logic [`ADDR_WIDTH-1:0]    id_ex_pc,
  input  logic [`ADDR_WIDTH-1:0]    id_ex_reg_address,
  input  logic [`ADDR_WIDTH-1:0]    id_ex_imm_address,
  output branch_pkg::flush_mask_t   flush,
  output logic [`ADDR_WIDTH-1:0]    jump_address,
  btb_if.update                     btb
);

  logic actual_taken;
  logic is_jr;
  logic mispredict;
  logic [`ADDR_WIDTH-1:0] fall_through;

  // resolve direction from the flags.
  always_comb begin
    actual_taken = 1'b0;
    case (jop)
      branch_pkg::J,
      branch_pkg::JR:  actual_taken = 1'b1;
      branch_pkg::JEQ,
      branch_pkg::JZ:  actual_taken = zero;
      branch_pkg::JNE,
      branch_pkg::JNZ: actual_taken = !zero;
      branch_pkg::JL:  actual_taken = less;
      branch_pkg::JLE: actual_taken = less | zero;     // equal counts.
      branch_pkg::JG:  actual_taken = greater;
      branch_pkg::JGE: actual_taken = greater | zero;  // equal counts.
      default:         actual_taken = 1'b0;            // nop and unused codes.
    endcase
  end

  assign is_jr = (jop == branch_pkg::JR);

  // register target is never predicted, so jr always redirects.
  assign mispredict = (actual_taken != branch_taken) || is_jr;

  assign flush = mispredict ? `PIPE_FLUSH_ALL : '0;

  assign fall_through = id_ex_pc + `ADDR_WIDTH'(1);

  always_comb begin
    if (is_jr) begin
      jump_address = id_ex_reg_address;
    end else if (!actual_taken) begin
      jump_address = fall_through;  // undo a wrong taken guess.
    end else begin
      jump_address = id_ex_imm_address;
    end
  end

  // train only on taken targets that a later lookup can reuse.
  assign btb.write     = mispredict && actual_taken && !is_jr;
  assign btb.write_key = id_ex_pc;
  assign btb.write_val = jump_address;

endmodule

`default_nettype wire

// ==== source/btb_if.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

interface btb_if;

  logic                   write;       // one cycle strobe.
  logic [`ADDR_WIDTH-1:0] write_key;
  logic [`ADDR_WIDTH-1:0] write_val;

  logic [`ADDR_WIDTH-1:0] read_key;    // fetch pc.
  logic [`ADDR_WIDTH-1:0] read_val;
  logic                   read_valid;

  // training side, execute stage.
  modport update (
    output write,
    output write_key,
    output write_val
  );

  // lookup side, fetch stage.
  modport fetch (
    output read_key,
    input  read_val,
    input  read_valid
  );

  modport lut (
    input  write,
    input  write_key,
    input  write_val,
    input  read_key,
    output read_val,
    output read_valid
  );

endinterface

`default_nettype wire

// ==== source/fetch_pc.sv ====
`timescale 1ns/10ps
`include "branch_consts.svh"
`default_nettype none

module fetch_pc (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stall,
  input  branch_pkg::flush_mask_t flush,
  input  logic [`ADDR_WIDTH-1:0]  jump_address,
  output logic [`ADDR_WIDTH-1:0]  pc,
  btb_if.fetch                    btb
);

  logic redirect;

  assign redirect = (flush & `PIPE_REG_PC) != '0;

  // lookup runs on the current pc.
  assign btb.read_key = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= jump_address;  // wins over stall.
    end else if (stall) begin
      pc <= pc;
    end else if (btb.read_valid) begin
      pc <= btb.read_val;  // follow prediction.
    end else begin
      pc <= pc + `ADDR_WIDTH'(1);
    end
  end

endmodule

`default_nettype wire
